// ==== source/riscv_isa_pkg.sv ====
// rv64 instruction fields and encodings, imported by any block that decodes an instruction word
`default_nettype none

package riscv_isa_pkg;

    localparam int inst_bits    = 32;
    localparam int reg_idx_bits = 5;

    // ************************************************************
    // major opcodes, inst[6:0]
    // ************************************************************
    localparam logic [6:0] opc_load      = 7'b0000011;
    localparam logic [6:0] opc_store     = 7'b0100011;
    localparam logic [6:0] opc_op_imm    = 7'b0010011;
    localparam logic [6:0] opc_op        = 7'b0110011;
    localparam logic [6:0] opc_op_imm_32 = 7'b0011011;  // addiw, slliw ...
    localparam logic [6:0] opc_op_32     = 7'b0111011;  // addw, subw ...
    localparam logic [6:0] opc_lui       = 7'b0110111;
    localparam logic [6:0] opc_auipc     = 7'b0010111;
    localparam logic [6:0] opc_system    = 7'b1110011;  // csr ops, ecall

    // funct3 under store and system
    localparam logic [2:0] f3_sb    = 3'b000;
    localparam logic [2:0] f3_sh    = 3'b001;
    localparam logic [2:0] f3_sw    = 3'b010;
    localparam logic [2:0] f3_sd    = 3'b011;
    localparam logic [2:0] f3_csrrw = 3'b001;
    localparam logic [2:0] f3_csrrs = 3'b010;

    // same 32 bits, read as r-type or as s-type
    typedef union packed {
        struct packed {
            logic [6:0]              funct7;
            logic [reg_idx_bits-1:0] rs2;
            logic [reg_idx_bits-1:0] rs1;
            logic [2:0]              funct3;
            logic [reg_idx_bits-1:0] rd;      // destination
            logic [6:0]              opcode;
        } r_fmt;
        struct packed {
            logic [6:0]              imm_hi;  // imm[11:5]
            logic [reg_idx_bits-1:0] rs2;     // store data source
            logic [reg_idx_bits-1:0] rs1;
            logic [2:0]              funct3;
            logic [4:0]              imm_lo;  // imm[4:0]
            logic [6:0]              opcode;
        } s_fmt;
    } inst_word_u;

endpackage

`default_nettype wire

// ==== source/mem_stage_pkg.sv ====
// data widths and internal op codes from decode, imported by every block of the memory stage
`default_nettype none

package mem_stage_pkg;

    localparam int xlen_bits = 64;  // data and address
    localparam int mask_bits = 8;   // one bit per byte lane
    localparam int op_bits   = 24;  // decoded op code width

    // ************************************************************
    // loads
    // ************************************************************
    localparam logic [op_bits-1:0] op_lb  = 24'd11;
    localparam logic [op_bits-1:0] op_lh  = 24'd12;
    localparam logic [op_bits-1:0] op_lw  = 24'd13;
    localparam logic [op_bits-1:0] op_lbu = 24'd14;
    localparam logic [op_bits-1:0] op_lhu = 24'd15;
    localparam logic [op_bits-1:0] op_lwu = 24'd41;
    localparam logic [op_bits-1:0] op_ld  = 24'd42;

    // ************************************************************
    // stores
    // ************************************************************
    localparam logic [op_bits-1:0] op_sb = 24'd16;
    localparam logic [op_bits-1:0] op_sh = 24'd17;
    localparam logic [op_bits-1:0] op_sw = 24'd18;
    localparam logic [op_bits-1:0] op_sd = 24'd43;

    // jumps, rd gets pc+4
    localparam logic [op_bits-1:0] op_jal  = 24'd4;
    localparam logic [op_bits-1:0] op_jalr = 24'h300;

    // csr ops, old csr value rides in src2
    localparam logic [op_bits-1:0] op_csrrw = 24'd49;
    localparam logic [op_bits-1:0] op_csrrs = 24'd50;

    // ************************************************************
    // alu subset, result straight from execute
    // ************************************************************
    localparam logic [op_bits-1:0] op_add   = 24'h4000;
    localparam logic [op_bits-1:0] op_addi  = 24'h100;
    localparam logic [op_bits-1:0] op_sub   = 24'h5000;
    localparam logic [op_bits-1:0] op_lui   = 24'h200;
    localparam logic [op_bits-1:0] op_auipc = 24'h400;
    localparam logic [op_bits-1:0] op_addw  = 24'h14000;  // sign fix already done in execute
    localparam logic [op_bits-1:0] op_slli  = 24'h800;

endpackage

`default_nettype wire

// ==== source/mem_pipe_reg.sv ====
// ex/mem pipeline register, loads on ready and zeroes its payload outputs for bubbles
`timescale 1ns/1ps
`default_nettype none

module mem_pipe_reg import mem_stage_pkg::*; import riscv_isa_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ready,       // downstream can take
    input  logic                 valid_in,
    input  logic [xlen_bits-1:0] pc_in,
    input  logic [inst_bits-1:0] inst_in,
    input  logic [op_bits-1:0]   op_in,
    input  logic [xlen_bits-1:0] alu_out_in,
    input  logic [xlen_bits-1:0] src2_in,
    output logic                 valid,
    output logic [xlen_bits-1:0] pc,
    output logic [inst_bits-1:0] inst,
    output logic [op_bits-1:0]   op,
    output logic [xlen_bits-1:0] alu_out,
    output logic [xlen_bits-1:0] src2
);

    logic                 valid_q;
    logic [xlen_bits-1:0] pc_q;
    logic [inst_bits-1:0] inst_q;
    logic [op_bits-1:0]   op_q;
    logic [xlen_bits-1:0] alu_out_q;
    logic [xlen_bits-1:0] src2_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (ready) begin
            valid_q <= valid_in;  // bubble in, bubble out
        end
    end

    // payload, held while ready is low
    always_ff @(posedge clk) begin
        if (ready) begin
            pc_q      <= pc_in;
            inst_q    <= inst_in;
            op_q      <= op_in;
            alu_out_q <= alu_out_in;
            src2_q    <= src2_in;
        end
    end

    // bubble shows op 0, so every decode below sees no access
    assign valid   = valid_q;
    assign pc      = valid_q ? pc_q      : '0;
    assign inst    = valid_q ? inst_q    : '0;
    assign op      = valid_q ? op_q      : '0;
    assign alu_out = valid_q ? alu_out_q : '0;
    assign src2    = valid_q ? src2_q    : '0;

endmodule

`default_nettype wire

// ==== source/store_fwd_unit.sv ====
// store-data bypass, takes the writeback value when the store's rs2 is being written back
`timescale 1ns/1ps
`default_nettype none

module store_fwd_unit import mem_stage_pkg::*; import riscv_isa_pkg::*; (
    input  logic                 mem_valid,
    input  inst_word_u           mem_inst,    // store in mem stage
    input  logic [xlen_bits-1:0] mem_src2,
    input  logic                 wb_valid,
    input  inst_word_u           wb_inst,     // instruction in writeback
    input  logic [xlen_bits-1:0] wb_wdata,
    output logic [xlen_bits-1:0] store_data
);

    logic mem_is_store;
    logic wb_writes_reg;
    logic rs2_hit;

    // mem side, s-type view
    always_comb begin
        mem_is_store = 1'b0;
        if (mem_inst.s_fmt.opcode == opc_store) begin
            case (mem_inst.s_fmt.funct3)
                f3_sb, f3_sh, f3_sw, f3_sd: mem_is_store = 1'b1;
                default:                    mem_is_store = 1'b0;
            endcase
        end
    end

    // wb side, r-type view; jumps are not counted here
    always_comb begin
        case (wb_inst.r_fmt.opcode)
            opc_load, opc_op_imm, opc_op_imm_32,
            opc_op, opc_op_32, opc_lui, opc_auipc: wb_writes_reg = 1'b1;
            opc_system: begin
                wb_writes_reg = (wb_inst.r_fmt.funct3 == f3_csrrw) ||
                                (wb_inst.r_fmt.funct3 == f3_csrrs);
            end
            default: wb_writes_reg = 1'b0;
        endcase
    end

    // x0 never forwards
    assign rs2_hit = (wb_inst.r_fmt.rd == mem_inst.s_fmt.rs2) &&
                     (mem_inst.s_fmt.rs2 != '0);

    assign store_data = (mem_valid && mem_is_store && wb_valid && wb_writes_reg && rs2_hit)
                        ? wb_wdata : mem_src2;

endmodule

`default_nettype wire

// ==== source/store_align.sv ====
// store address, lane-shifted write data and byte mask for the data memory
`timescale 1ns/1ps
`default_nettype none

module store_align import mem_stage_pkg::*; (
    input  logic [op_bits-1:0]   op,
    input  logic [xlen_bits-1:0] alu_out,     // effective address
    input  logic [xlen_bits-1:0] store_data,  // already forwarded
    output logic [xlen_bits-1:0] waddr,
    output logic [xlen_bits-1:0] wdata,
    output logic [mask_bits-1:0] wmask
);

    logic [2:0] lane;  // byte offset in the double word

    assign lane = alu_out[2:0];

    always_comb begin
        waddr = '0;
        wdata = '0;
        wmask = '0;  // no write
        case (op)
            op_sb: begin
                waddr = alu_out;
                wdata = {56'b0, store_data[7:0]} << {lane, 3'b000};
                wmask = 8'h01 << lane;
            end
            op_sh: begin
                waddr = alu_out;
                if (lane != 3'd7) begin  // crossing half drops out
                    wdata = {48'b0, store_data[15:0]} << {lane, 3'b000};
                    wmask = 8'h03 << lane;
                end
            end
            op_sw: begin
                waddr = alu_out;
                if (lane[2]) begin
                    wdata = {store_data[31:0], 32'b0};  // upper word
                    wmask = 8'hf0;
                end else begin
                    wdata = {32'b0, store_data[31:0]};
                    wmask = 8'h0f;
                end
            end
            op_sd: begin
                waddr = alu_out;
                wdata = store_data;
                wmask = 8'hff;  // all lanes
            end
            default: begin
                waddr = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/load_align.sv ====
// load address to the data memory, lane extraction and sign or zero extension of the result
`timescale 1ns/1ps
`default_nettype none

module load_align import mem_stage_pkg::*; (
    input  logic [op_bits-1:0]   op,
    input  logic [xlen_bits-1:0] alu_out,    // effective address
    output logic [xlen_bits-1:0] raddr,
    input  logic [xlen_bits-1:0] rdata,      // same-cycle memory data
    output logic [xlen_bits-1:0] load_value
);

    logic                 is_load;
    logic [2:0]           lane;
    logic [xlen_bits-1:0] shifted;  // addressed byte moved to lane 0
    logic [7:0]           byte_val;
    logic [15:0]          half_val;
    logic [31:0]          word_val;

    always_comb begin
        case (op)
            op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld: is_load = 1'b1;
            default:                                          is_load = 1'b0;
        endcase
    end

    assign raddr = is_load ? alu_out : '0;
    assign lane  = raddr[2:0];

    assign shifted  = rdata >> {lane, 3'b000};
    assign byte_val = shifted[7:0];
    assign half_val = (lane == 3'd7) ? 16'b0 : shifted[15:0];  // no crossing
    assign word_val = lane[2] ? rdata[63:32] : rdata[31:0];

    // extension by op
    always_comb begin
        case (op)
            op_lb:   load_value = {{56{byte_val[7]}}, byte_val};
            op_lh:   load_value = {{48{half_val[15]}}, half_val};
            op_lw:   load_value = {{32{word_val[31]}}, word_val};
            op_lbu:  load_value = {56'b0, byte_val};
            op_lhu:  load_value = {48'b0, half_val};
            op_lwu:  load_value = {32'b0, word_val};
            op_ld:   load_value = rdata;  // full double
            default: load_value = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/wb_select.sv ====
// register write enable, destination and value for the writeback stage
`timescale 1ns/1ps
`default_nettype none

module wb_select import mem_stage_pkg::*; import riscv_isa_pkg::*; (
    input  logic                    valid,
    input  logic [op_bits-1:0]      op,
    input  logic [xlen_bits-1:0]    pc,
    input  inst_word_u              inst,
    input  logic [xlen_bits-1:0]    alu_out,
    input  logic [xlen_bits-1:0]    src2,        // old csr value for csr ops
    input  logic [xlen_bits-1:0]    load_value,
    output logic                    reg_wen,
    output logic [reg_idx_bits-1:0] reg_rd,
    output logic [xlen_bits-1:0]    reg_wdata
);

    logic [xlen_bits-1:0] link_addr;

    assign link_addr = pc + 64'd4;  // return address for jal/jalr

    // ************************************************************
    // result mux by op class
    // ************************************************************
    always_comb begin
        case (op)
            op_add, op_addi, op_sub, op_lui,
            op_auipc, op_addw, op_slli: begin
                reg_wen   = 1'b1;
                reg_wdata = alu_out;
            end
            op_jal, op_jalr: begin
                reg_wen   = 1'b1;
                reg_wdata = link_addr;
            end
            op_lb, op_lh, op_lw, op_lbu,
            op_lhu, op_lwu, op_ld: begin
                reg_wen   = 1'b1;
                reg_wdata = load_value;
            end
            op_csrrw, op_csrrs: begin
                reg_wen   = 1'b1;
                reg_wdata = src2;
            end
            default: begin  // stores, bubbles
                reg_wen   = 1'b0;
                reg_wdata = '0;
            end
        endcase
    end

    // bubble reports x0
    assign reg_rd = valid ? inst.r_fmt.rd : '0;

endmodule

`default_nettype wire

// ==== source/mem_stage_top.sv ====
// memory-access stage of the rv64 pipeline, placed between execute and writeback
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top import mem_stage_pkg::*; import riscv_isa_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    // from execute
    input  logic                    valid_ex,
    output logic                    ready_ex,
    input  logic [xlen_bits-1:0]    pc_ex,
    input  logic [inst_bits-1:0]    inst_ex,
    input  logic [op_bits-1:0]      op_ex,
    input  logic [xlen_bits-1:0]    alu_out_ex,
    input  logic [xlen_bits-1:0]    src2_ex,
    // to writeback
    output logic                    valid_wb,
    input  logic                    ready_wb,
    output logic [xlen_bits-1:0]    pc_wb,
    output logic [inst_bits-1:0]    inst_wb,
    output logic                    reg_wen,
    output logic [reg_idx_bits-1:0] reg_rd,
    output logic [xlen_bits-1:0]    reg_wdata,
    // instruction now in writeback, for store forwarding
    input  logic                    wb_valid,
    input  logic [inst_bits-1:0]    wb_inst,
    input  logic [xlen_bits-1:0]    wb_wdata,
    // data memory
    output logic [xlen_bits-1:0]    mem_raddr,
    input  logic [xlen_bits-1:0]    mem_rdata,
    output logic [xlen_bits-1:0]    mem_waddr,
    output logic [xlen_bits-1:0]    mem_wdata,
    output logic [mask_bits-1:0]    mem_wmask
);

    logic                 mem_valid;
    logic [xlen_bits-1:0] mem_pc;
    logic [inst_bits-1:0] mem_inst;
    logic [op_bits-1:0]   mem_op;
    logic [xlen_bits-1:0] mem_alu_out;
    logic [xlen_bits-1:0] mem_src2;
    logic [xlen_bits-1:0] store_data;  // src2 after forwarding
    logic [xlen_bits-1:0] load_value;  // extracted and extended

    assign ready_ex = ready_wb;  // stage never stalls by itself

    assign valid_wb = mem_valid;
    assign pc_wb    = mem_pc;
    assign inst_wb  = mem_inst;

    // ************************************************************
    // ex/mem register
    // ************************************************************
    mem_pipe_reg u_pipe (
        .clk(clk), .rst(rst), .ready(ready_ex),
        .valid_in(valid_ex), .pc_in(pc_ex), .inst_in(inst_ex), .op_in(op_ex),
        .alu_out_in(alu_out_ex), .src2_in(src2_ex),
        .valid(mem_valid), .pc(mem_pc), .inst(mem_inst), .op(mem_op),
        .alu_out(mem_alu_out), .src2(mem_src2)
    );

    store_fwd_unit u_fwd (
        .mem_valid(mem_valid), .mem_inst(mem_inst), .mem_src2(mem_src2),
        .wb_valid(wb_valid), .wb_inst(wb_inst), .wb_wdata(wb_wdata),
        .store_data(store_data)
    );

    // ************************************************************
    // memory side
    // ************************************************************
    store_align u_st (
        .op(mem_op), .alu_out(mem_alu_out), .store_data(store_data),
        .waddr(mem_waddr), .wdata(mem_wdata), .wmask(mem_wmask)
    );

    load_align u_ld (
        .op(mem_op), .alu_out(mem_alu_out), .raddr(mem_raddr),
        .rdata(mem_rdata), .load_value(load_value)
    );

    wb_select u_wbsel (
        .valid(mem_valid), .op(mem_op), .pc(mem_pc), .inst(mem_inst),
        .alu_out(mem_alu_out), .src2(mem_src2), .load_value(load_value),
        .reg_wen(reg_wen), .reg_rd(reg_rd), .reg_wdata(reg_wdata)
    );

endmodule

`default_nettype wire

// ==== verification/mem_stage_ref.sv ====
// reference rules for the memory stage, instanced by the testbench as ref_model
`timescale 1ns/1ps
`default_nettype none

module mem_stage_ref import mem_stage_pkg::*; import riscv_isa_pkg::*; ();

    // bytes moved by a load or store op, 0 for anything else
    function automatic int access_size(input logic [op_bits-1:0] op);
        case (op)
            op_lb, op_lbu, op_sb: return 1;
            op_lh, op_lhu, op_sh: return 2;
            op_lw, op_lwu, op_sw: return 4;
            op_ld, op_sd:         return 8;
            default:              return 0;
        endcase
    endfunction

    // first lane touched, -1 when the access falls out (half at lane 7)
    function automatic int first_lane(input int size, input logic [2:0] off);
        if (size == 8) return 0;
        if (size == 4) return off[2] ? 4 : 0;
        if (size == 2 && off == 3'd7) return -1;
        return int'(off);
    endfunction

    function automatic bit is_load_op(input logic [op_bits-1:0] op);
        return op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld};
    endfunction

    function automatic bit is_store_op(input logic [op_bits-1:0] op);
        return op inside {op_sb, op_sh, op_sw, op_sd};
    endfunction

    // register-writing instruction classes, seen from writeback
    function automatic bit inst_writes_reg(input logic [31:0] inst);
        if (inst[6:0] == opc_system)
            return (inst[14:12] == 3'b001) || (inst[14:12] == 3'b010);
        return inst[6:0] inside {opc_load, opc_op_imm, opc_op_imm_32, opc_op,
                                 opc_op_32, opc_lui, opc_auipc};
    endfunction

    // {mask, data} that a store puts on the memory port
    function automatic logic [71:0] store_lanes(input logic [op_bits-1:0] op,
                                                input logic [2:0] off,
                                                input logic [63:0] data);
        int size;
        int base;
        logic [63:0] wd;
        logic [7:0]  wm;
        size = access_size(op);
        base = first_lane(size, off);
        wd   = '0;
        wm   = '0;
        if (is_store_op(op) && base >= 0) begin
            for (int i = 0; i < size; i++) begin
                wm[base+i]         = 1'b1;
                wd[(base+i)*8 +: 8] = data[i*8 +: 8];
            end
        end
        return {wm, wd};
    endfunction

    // loaded value, gathered byte by byte then extended
    function automatic logic [63:0] load_extract(input logic [op_bits-1:0] op,
                                                 input logic [2:0] off,
                                                 input logic [63:0] word);
        int size;
        int base;
        logic [63:0] v;
        size = access_size(op);
        base = first_lane(size, off);
        v    = '0;
        if (!is_load_op(op) || base < 0) return '0;
        for (int i = 0; i < size; i++) v[i*8 +: 8] = word[(base+i)*8 +: 8];
        if (op inside {op_lb, op_lh, op_lw} && v[size*8-1]) begin
            for (int i = size*8; i < 64; i++) v[i] = 1'b1;  // sign fill
        end
        return v;
    endfunction

endmodule

`default_nettype wire

// ==== verification/mem_stage_tb.sv ====
// testbench for the memory stage with random items, a memory model, a timeout and assertion checks
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb import mem_stage_pkg::*; import riscv_isa_pkg::*; ();

    localparam int per_phase = 80;
    localparam int n_items   = 4 * per_phase;
    localparam int cycle_limit = n_items * 4 + 50;

    logic clk = 1'b0, rst, valid_ex, ready_ex, ready_wb, valid_wb, reg_wen, wb_valid;
    logic [63:0] pc_ex, alu_out_ex, src2_ex, pc_wb, reg_wdata, wb_wdata;
    logic [63:0] mem_raddr, mem_rdata, mem_waddr, mem_wdata;
    logic [31:0] inst_ex, inst_wb, wb_inst;
    logic [23:0] op_ex;
    logic [4:0]  reg_rd;
    logic [7:0]  mem_wmask;
    logic [7:0]  mem [256];      // model driving the DUT
    logic [7:0]  ref_mem [256];  // expected contents
    // expected EX/MEM contents
    logic        e_valid, checking;
    logic [63:0] e_pc, e_alu, e_src2;
    logic [31:0] e_inst;
    logic [23:0] e_op;
    // expected outputs
    logic [63:0] x_wdata, x_raddr, x_waddr, x_mwdata, x_sdata, x_word, x_pc;
    logic [31:0] x_inst;
    logic [4:0]  x_rd;
    logic [7:0]  x_wmask;
    logic        x_wen;
    int          cycles, seed_val;

    mem_stage_top dut (.*);
    mem_stage_ref ref_model ();

    always #20 clk = ~clk;  // 40 ns period

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            mem_rdata[i*8 +: 8] = mem[{mem_raddr[7:3], 3'(i)}];
        end
    end

    always @(posedge clk) begin
        for (int i = 0; i < 8; i++) begin
            if (mem_wmask[i] === 1'b1) mem[{mem_waddr[7:3], 3'(i)}] <= mem_wdata[i*8 +: 8];
            if (checking && x_wmask[i]) ref_mem[{x_waddr[7:3], 3'(i)}] <= x_mwdata[i*8 +: 8];
        end
    end

    // ************************************************************
    // expected register and outputs
    // ************************************************************
    always @(posedge clk) begin
        checking <= 1'b1;
        if (rst) e_valid <= 1'b0;
        else if (ready_wb) begin
            e_valid <= valid_ex;
            {e_pc, e_inst, e_op, e_alu, e_src2} <= {pc_ex, inst_ex, op_ex, alu_out_ex, src2_ex};
        end
    end

    always_comb begin
        logic [23:0] op;
        op     = e_valid ? e_op : '0;
        x_pc   = e_valid ? e_pc : '0;
        x_inst = e_valid ? e_inst : '0;
        x_rd   = e_valid ? e_inst[11:7] : '0;
        for (int i = 0; i < 8; i++) x_word[i*8 +: 8] = ref_mem[{e_alu[7:3], 3'(i)}];
        x_sdata = (e_valid && e_inst[6:0] == opc_store && wb_valid
                   && ref_model.inst_writes_reg(wb_inst)
                   && wb_inst[11:7] == e_inst[24:20] && e_inst[24:20] != 0)
                  ? wb_wdata : e_src2;
        {x_wmask, x_mwdata} = ref_model.store_lanes(op, e_alu[2:0], x_sdata);
        x_waddr = ref_model.is_store_op(op) ? e_alu : '0;
        x_raddr = ref_model.is_load_op(op) ? e_alu : '0;
        x_wen   = 1'b1;
        if (ref_model.is_load_op(op)) x_wdata = ref_model.load_extract(op, e_alu[2:0], x_word);
        else if (op inside {op_jal, op_jalr}) x_wdata = e_pc + 64'd4;
        else if (op inside {op_csrrw, op_csrrs}) x_wdata = e_src2;
        else if (op inside {op_add, op_addi, op_sub, op_lui, op_auipc, op_addw, op_slli})
            x_wdata = e_alu;
        else begin
            x_wdata = '0;
            x_wen   = 1'b0;
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] got, exp);
        $display("mismatch %s: got %h expected %h", name, got, exp);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    // ************************************************************
    // assertions
    // ************************************************************
    a_reset: assert property (@(posedge clk) (checking && rst) |-> (!valid_wb && !reg_wen
        && mem_wmask == 0 && mem_raddr == 0 && mem_waddr == 0))
        else report_error("outputs not idle during reset");
    a_valid: assert property (@(posedge clk) checking |-> valid_wb == e_valid)
        else report_mismatch("valid_wb", $sampled(valid_wb), $sampled(e_valid));
    a_pc: assert property (@(posedge clk) checking |-> pc_wb == x_pc)
        else report_mismatch("pc_wb", $sampled(pc_wb), $sampled(x_pc));
    a_inst: assert property (@(posedge clk) checking |-> inst_wb == x_inst)
        else report_mismatch("inst_wb", $sampled(inst_wb), $sampled(x_inst));
    a_wen: assert property (@(posedge clk) checking |-> reg_wen == x_wen)
        else report_mismatch("reg_wen", $sampled(reg_wen), $sampled(x_wen));
    a_rd: assert property (@(posedge clk) checking |-> reg_rd == x_rd)
        else report_mismatch("reg_rd", $sampled(reg_rd), $sampled(x_rd));
    a_wdata: assert property (@(posedge clk) checking |-> reg_wdata == x_wdata)
        else report_mismatch("reg_wdata", $sampled(reg_wdata), $sampled(x_wdata));
    a_raddr: assert property (@(posedge clk) checking |-> mem_raddr == x_raddr)
        else report_mismatch("mem_raddr", $sampled(mem_raddr), $sampled(x_raddr));
    a_waddr: assert property (@(posedge clk) checking |-> mem_waddr == x_waddr)
        else report_mismatch("mem_waddr", $sampled(mem_waddr), $sampled(x_waddr));
    a_mwdata: assert property (@(posedge clk) checking |-> mem_wdata == x_mwdata)
        else report_mismatch("mem_wdata", $sampled(mem_wdata), $sampled(x_mwdata));
    a_wmask: assert property (@(posedge clk) checking |-> mem_wmask == x_wmask)
        else report_mismatch("mem_wmask", $sampled(mem_wmask), $sampled(x_wmask));
    a_ready: assert property (@(posedge clk) checking |-> ready_ex == ready_wb)
        else report_mismatch("ready_ex", $sampled(ready_ex), $sampled(ready_wb));
    a_hold: assert property (@(posedge clk) (checking && !rst && !ready_wb) |=>
        ($stable(valid_wb) && $stable(pc_wb) && $stable(inst_wb) && $stable(reg_wen)
         && $stable(reg_rd) && $stable(reg_wdata) && $stable(mem_raddr)
         && $stable(mem_waddr) && $stable(mem_wdata) && $stable(mem_wmask)))
        else report_error("outputs changed while ready_wb was low");

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) report_error("timeout, items stopped being accepted");
    end

    // ************************************************************
    // stimulus
    // ************************************************************
    task automatic step_ctrl();
        logic [6:0] opc [5];
        opc = '{opc_load, opc_op, opc_store, opc_system, 7'b1101111};
        if (ready_wb) begin  // wb side held while stalled
            wb_valid = ($urandom % 4) != 0;
            wb_inst  = {17'($urandom), 3'b001, 5'($urandom % 4), opc[$urandom % 5]};
            wb_wdata = {$urandom, $urandom};
        end
        ready_wb = ($urandom % 4) != 0;
    endtask

    task automatic send_item(input logic [23:0] op, input logic [6:0] opc, input logic [2:0] f3,
                             input logic [4:0] rs2);
        @(negedge clk);
        valid_ex   = 1'b1;
        op_ex      = op;
        inst_ex    = {7'($urandom), rs2, 5'($urandom), f3, 5'($urandom), opc};
        pc_ex      = {$urandom, $urandom};
        alu_out_ex = {$urandom, $urandom};
        src2_ex    = {$urandom, $urandom};
        step_ctrl();
        @(posedge clk);
        while (!ready_wb) begin  // wait for acceptance
            @(negedge clk);
            step_ctrl();
            @(posedge clk);
        end
    endtask

    initial begin
        logic [23:0] exec_ops [11];
        logic [23:0] ld_ops [7];
        logic [23:0] st_ops [4];
        bit          same;
        exec_ops = '{op_add, op_addi, op_sub, op_lui, op_auipc, op_addw, op_slli,
                     op_jal, op_jalr, op_csrrw, op_csrrs};
        ld_ops   = '{op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld};
        st_ops   = '{op_sb, op_sh, op_sw, op_sd};
        seed_val = $urandom(35302);
        for (int i = 0; i < 256; i++) begin
            mem[i]     = 8'(i * 8'd37) ^ 8'h5a;  // differs at every address
            ref_mem[i] = 8'(i * 8'd37) ^ 8'h5a;
        end
        {valid_ex, pc_ex, inst_ex, op_ex, alu_out_ex, src2_ex} = '0;
        {wb_valid, wb_inst, wb_wdata} = '0;
        cycles   = 0;
        checking = 1'b0;
        ready_wb = 1'b1;
        rst      = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk) rst = 1'b0;
        for (int i = 0; i < per_phase; i++) begin
            send_item(exec_ops[$urandom % 11], opc_op, 3'b0, 5'($urandom));
        end
        for (int i = 0; i < per_phase; i++) begin
            send_item(ld_ops[$urandom % 7], opc_load, 3'b0, 5'($urandom));
        end
        for (int i = 0; i < per_phase; i++) begin
            int k;
            k = $urandom % 4;
            send_item(st_ops[k], opc_store, 3'(k), 5'($urandom));
        end
        // small rs2 range so stores often meet a wb rd
        for (int i = 0; i < per_phase; i++) begin
            int k;
            k = $urandom % 4;
            send_item(st_ops[k], opc_store, 3'(k), 5'($urandom % 4));
        end
        @(negedge clk);
        valid_ex = 1'b0;
        ready_wb = 1'b1;
        repeat (3) @(posedge clk);
        same = 1'b1;
        for (int i = 0; i < 256; i++) begin
            if (mem[i] !== ref_mem[i]) same = 1'b0;
        end
        if (same) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("memory contents differ from the expected stores");
            $display("Regression failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
source/riscv_isa_pkg.sv
source/mem_stage_pkg.sv
source/mem_pipe_reg.sv
source/store_fwd_unit.sv
source/store_align.sv
source/load_align.sv
source/wb_select.sv
source/mem_stage_top.sv
verification/mem_stage_ref.sv
verification/mem_stage_tb.sv

// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  # packages first
  - source/riscv_isa_pkg.sv
  - source/mem_stage_pkg.sv
  # rtl
  - source/mem_pipe_reg.sv
  - source/store_fwd_unit.sv
  - source/store_align.sv
  - source/load_align.sv
  - source/wb_select.sv
  - source/mem_stage_top.sv
  # testbench
  - target: test
    files:
      - verification/mem_stage_ref.sv
      - verification/mem_stage_tb.sv
